//--- compile.f
source/rv64_pkg.sv
source/rv64_idu.sv
source/rv64_regfile.sv
source/rv64_alu.sv
source/rv64_id_stage.sv
source/rv64_ex_stage.sv
source/rv64_core_pipe.sv
test/tb_clock_gen.sv
test/tb_rv64_core_pipe.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the RV64 execute pipe testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_rv64_core_pipe -Mdir obj_dir -o sim_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- source/rv64_alu.sv
// single-cycle 64-bit ALU; mul returns the low 64 bits, word ops sign-extend bit 31
`timescale 1ns/1ps

module rv64_alu (
  input  logic [rv64_pkg::XLEN-1:0]     i_a,
  input  logic [rv64_pkg::XLEN-1:0]     i_b,
  input  logic [rv64_pkg::ALU_OP_W-1:0] i_op,
  input  logic                          i_word_cut,
  output logic [rv64_pkg::XLEN-1:0]     o_result,
  output logic                          o_zero_less,
  output logic                          o_uless,
  output logic                          o_equal
);

  logic [rv64_pkg::XLEN-1:0] a_op;
  logic [rv64_pkg::XLEN-1:0] raw;
  logic [5:0]                shamt;

  // word shifts see a 32-bit operand, sign-filled only for sraw
  assign a_op  = i_word_cut ?
                 {{32{i_a[31] & (i_op == rv64_pkg::ALU_SRA)}}, i_a[31:0]} : i_a;
  assign shamt = i_word_cut ? {1'b0, i_b[4:0]} : i_b[5:0];

  assign o_equal     = (i_a == i_b);
  assign o_zero_less = ($signed(i_a) < $signed(i_b));
  assign o_uless     = (i_a < i_b);

  always_comb begin
    case (i_op)
      rv64_pkg::ALU_ADD:    raw = a_op + i_b;
      rv64_pkg::ALU_SUB:    raw = a_op - i_b;
      rv64_pkg::ALU_SLT:    raw = {{(rv64_pkg::XLEN-1){1'b0}}, o_zero_less};
      rv64_pkg::ALU_SLTU:   raw = {{(rv64_pkg::XLEN-1){1'b0}}, o_uless};
      rv64_pkg::ALU_XOR:    raw = a_op ^ i_b;
      rv64_pkg::ALU_AND:    raw = a_op & i_b;
      rv64_pkg::ALU_OR:     raw = a_op | i_b;
      rv64_pkg::ALU_SLL:    raw = a_op << shamt;
      rv64_pkg::ALU_SRL:    raw = a_op >> shamt;
      rv64_pkg::ALU_SRA:    raw = $unsigned($signed(a_op) >>> shamt);
      rv64_pkg::ALU_COPY_B: raw = i_b;
      rv64_pkg::ALU_MUL:    raw = a_op * i_b;
      default:              raw = '0;  // ALU_NONE
    endcase
  end

  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

//--- source/rv64_core_pipe.sv
// two-stage RV64I execute pipe; no fetch, no back-pressure, fixed one-cycle output latency
`timescale 1ns/1ps

module rv64_core_pipe (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic                            i_inst_valid,
  input  logic [31:0]                     i_inst,
  input  logic [rv64_pkg::XLEN-1:0]       i_pc,
  output logic                            o_wb_valid,
  output logic                            o_wb_we,
  output logic [rv64_pkg::REG_ADDR_W-1:0] o_wb_rd,
  output logic [rv64_pkg::XLEN-1:0]       o_wb_data,
  output logic                            o_redirect,
  output logic [rv64_pkg::XLEN-1:0]       o_redirect_pc,
  output logic                            o_ebreak,
  output logic                            o_illegal
);

  logic [rv64_pkg::REG_ADDR_W-1:0] ra, rb, ex_rd, id_rd;
  logic [rv64_pkg::XLEN-1:0]       rdata_a, rdata_b, ex_result;
  logic [rv64_pkg::XLEN-1:0]       id_pc, id_a_val, id_b_val, id_imm;
  logic [rv64_pkg::ALU_OP_W-1:0]   id_alu_op;
  logic [1:0]                      id_bsrc;
  logic [rv64_pkg::BR_W-1:0]       id_branch;
  logic ex_we, id_valid, id_asrc, id_word_cut, id_reg_wr, id_ebreak, id_illegal;

  rv64_id_stage rv64_id_stage_i (
    .i_clk        (i_clk),        .i_rst_n     (i_rst_n),
    .i_inst_valid (i_inst_valid), .i_inst      (i_inst),      .i_pc       (i_pc),
    .o_ra         (ra),           .o_rb        (rb),
    .i_rdata_a    (rdata_a),      .i_rdata_b   (rdata_b),
    .i_ex_we      (ex_we),        .i_ex_rd     (ex_rd),       .i_ex_result (ex_result),
    .o_valid      (id_valid),     .o_pc        (id_pc),
    .o_a_val      (id_a_val),     .o_b_val     (id_b_val),    .o_imm      (id_imm),
    .o_rd         (id_rd),        .o_alu_op    (id_alu_op),
    .o_asrc       (id_asrc),      .o_bsrc      (id_bsrc),     .o_branch   (id_branch),
    .o_word_cut   (id_word_cut),  .o_reg_wr    (id_reg_wr),
    .o_ebreak     (id_ebreak),    .o_illegal   (id_illegal)
  );

  rv64_regfile rv64_regfile_i (
    .i_clk     (i_clk),   .i_rst_n   (i_rst_n),
    .i_ra      (ra),      .i_rb      (rb),
    .o_rdata_a (rdata_a), .o_rdata_b (rdata_b),
    .i_we      (ex_we),   .i_wa      (ex_rd),  .i_wdata (ex_result)
  );

  rv64_ex_stage rv64_ex_stage_i (
    .i_clk       (i_clk),       .i_rst_n     (i_rst_n),
    .i_valid     (id_valid),    .i_pc        (id_pc),
    .i_a_val     (id_a_val),    .i_b_val     (id_b_val),   .i_imm     (id_imm),
    .i_rd        (id_rd),       .i_alu_op    (id_alu_op),
    .i_asrc      (id_asrc),     .i_bsrc      (id_bsrc),    .i_branch  (id_branch),
    .i_word_cut  (id_word_cut), .i_reg_wr    (id_reg_wr),
    .i_ebreak    (id_ebreak),   .i_illegal   (id_illegal),
    .o_ex_we     (ex_we),       .o_ex_rd     (ex_rd),      .o_ex_result (ex_result),
    .o_wb_valid  (o_wb_valid),  .o_wb_we     (o_wb_we),
    .o_wb_rd     (o_wb_rd),     .o_wb_data   (o_wb_data),
    .o_redirect  (o_redirect),  .o_redirect_pc (o_redirect_pc),
    .o_ebreak    (o_ebreak),    .o_illegal   (o_illegal)
  );

endmodule

//--- source/rv64_ex_stage.sv
// execute and writeback register; redirects are reported only, younger work is not squashed
`timescale 1ns/1ps

module rv64_ex_stage (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic                            i_valid,
  input  logic [rv64_pkg::XLEN-1:0]       i_pc,
  input  logic [rv64_pkg::XLEN-1:0]       i_a_val,
  input  logic [rv64_pkg::XLEN-1:0]       i_b_val,
  input  logic [rv64_pkg::XLEN-1:0]       i_imm,
  input  logic [rv64_pkg::REG_ADDR_W-1:0] i_rd,
  input  logic [rv64_pkg::ALU_OP_W-1:0]   i_alu_op,
  input  logic                            i_asrc,
  input  logic [1:0]                      i_bsrc,
  input  logic [rv64_pkg::BR_W-1:0]       i_branch,
  input  logic                            i_word_cut,
  input  logic                            i_reg_wr,
  input  logic                            i_ebreak,
  input  logic                            i_illegal,
  output logic                            o_ex_we,
  output logic [rv64_pkg::REG_ADDR_W-1:0] o_ex_rd,
  output logic [rv64_pkg::XLEN-1:0]       o_ex_result,
  output logic                            o_wb_valid,
  output logic                            o_wb_we,
  output logic [rv64_pkg::REG_ADDR_W-1:0] o_wb_rd,
  output logic [rv64_pkg::XLEN-1:0]       o_wb_data,
  output logic                            o_redirect,
  output logic [rv64_pkg::XLEN-1:0]       o_redirect_pc,
  output logic                            o_ebreak,
  output logic                            o_illegal
);

  logic [rv64_pkg::XLEN-1:0] op_a;
  logic [rv64_pkg::XLEN-1:0] op_b;
  logic [rv64_pkg::XLEN-1:0] target;
  logic zero_less, uless, equal, less, taken;

  assign op_a = (i_asrc == rv64_pkg::ASRC_PC) ? i_pc : i_a_val;
  assign op_b = (i_bsrc == rv64_pkg::BSRC_IMM)  ? i_imm :
                (i_bsrc == rv64_pkg::BSRC_FOUR) ? 64'd4 : i_b_val;

  rv64_alu rv64_alu_i (
    .i_a         (op_a),
    .i_b         (op_b),
    .i_op        (i_alu_op),
    .i_word_cut  (i_word_cut),
    .o_result    (o_ex_result),
    .o_zero_less (zero_less),
    .o_uless     (uless),
    .o_equal     (equal)
  );

  assign less = (i_alu_op == rv64_pkg::ALU_SLTU) ? uless : zero_less;

  always_comb begin
    case (i_branch)
      rv64_pkg::BR_JAL, rv64_pkg::BR_JALR: taken = 1'b1;
      rv64_pkg::BR_EQ: taken = equal;
      rv64_pkg::BR_NE: taken = !equal;
      rv64_pkg::BR_LT: taken = less;   // also bltu
      rv64_pkg::BR_GE: taken = !less;  // also bgeu
      default:         taken = 1'b0;
    endcase
  end

  assign target = (i_branch == rv64_pkg::BR_JALR) ? ((i_a_val + i_imm) & ~64'd1) : i_pc + i_imm;

  assign o_ex_we = i_valid & i_reg_wr;  // also the regfile write port
  assign o_ex_rd = i_rd;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
      o_wb_we    <= 1'b0;
      o_redirect <= 1'b0;
      o_ebreak   <= 1'b0;
      o_illegal  <= 1'b0;
    end else begin
      o_wb_valid <= i_valid;
      o_wb_we    <= o_ex_we;
      o_redirect <= i_valid & taken;
      o_ebreak   <= i_valid & i_ebreak;
      o_illegal  <= i_valid & i_illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb_rd       <= i_rd;
    o_wb_data     <= o_ex_result;
    o_redirect_pc <= target;
  end

  // decoder never flags a branch on an illegal word
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_redirect |-> o_wb_valid && !o_illegal);

endmodule

//--- source/rv64_id_stage.sv
// decode with ex-stage bypass; no hazard stall since ex results are ready in one cycle
`timescale 1ns/1ps

module rv64_id_stage (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic                            i_inst_valid,
  input  logic [31:0]                     i_inst,
  input  logic [rv64_pkg::XLEN-1:0]       i_pc,
  output logic [rv64_pkg::REG_ADDR_W-1:0] o_ra,
  output logic [rv64_pkg::REG_ADDR_W-1:0] o_rb,
  input  logic [rv64_pkg::XLEN-1:0]       i_rdata_a,
  input  logic [rv64_pkg::XLEN-1:0]       i_rdata_b,
  input  logic                            i_ex_we,
  input  logic [rv64_pkg::REG_ADDR_W-1:0] i_ex_rd,
  input  logic [rv64_pkg::XLEN-1:0]       i_ex_result,
  output logic                            o_valid,
  output logic [rv64_pkg::XLEN-1:0]       o_pc,
  output logic [rv64_pkg::XLEN-1:0]       o_a_val,
  output logic [rv64_pkg::XLEN-1:0]       o_b_val,
  output logic [rv64_pkg::XLEN-1:0]       o_imm,
  output logic [rv64_pkg::REG_ADDR_W-1:0] o_rd,
  output logic [rv64_pkg::ALU_OP_W-1:0]   o_alu_op,
  output logic                            o_asrc,
  output logic [1:0]                      o_bsrc,
  output logic [rv64_pkg::BR_W-1:0]       o_branch,
  output logic                            o_word_cut,
  output logic                            o_reg_wr,
  output logic                            o_ebreak,
  output logic                            o_illegal
);

  logic [rv64_pkg::XLEN-1:0]       imm;
  logic [rv64_pkg::REG_ADDR_W-1:0] rd;
  logic [rv64_pkg::ALU_OP_W-1:0]   alu_op;
  logic [1:0]                      bsrc;
  logic [rv64_pkg::BR_W-1:0]       branch;
  logic asrc, word_cut, reg_wr, ebreak, illegal;

  rv64_idu rv64_idu_i (
    .i_inst     (i_inst),
    .o_imm      (imm),
    .o_rs1      (o_ra),
    .o_rs2      (o_rb),
    .o_rd       (rd),
    .o_alu_op   (alu_op),
    .o_asrc     (asrc),
    .o_bsrc     (bsrc),
    .o_branch   (branch),
    .o_word_cut (word_cut),
    .o_reg_wr   (reg_wr),
    .o_ebreak   (ebreak),
    .o_illegal  (illegal)
  );

  wire byp_a = i_ex_we && (i_ex_rd != '0) && (i_ex_rd == o_ra);
  wire byp_b = i_ex_we && (i_ex_rd != '0) && (i_ex_rd == o_rb);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n)
      o_valid <= 1'b0;
    else
      o_valid <= i_inst_valid;
  end

  always_ff @(posedge i_clk) begin  // payload, qualified by o_valid
    o_pc       <= i_pc;
    o_a_val    <= byp_a ? i_ex_result : i_rdata_a;
    o_b_val    <= byp_b ? i_ex_result : i_rdata_b;
    o_imm      <= imm;
    o_rd       <= rd;
    o_alu_op   <= alu_op;
    o_asrc     <= asrc;
    o_bsrc     <= bsrc;
    o_branch   <= branch;
    o_word_cut <= word_cut;
    o_reg_wr   <= reg_wr;
    o_ebreak   <= ebreak;
    o_illegal  <= illegal;
  end

  assert property (@(posedge i_clk) disable iff (!i_rst_n) o_valid |-> !(o_reg_wr && o_illegal));

endmodule

//--- source/rv64_idu.sv
// RV64I plus mul/mulw only; loads, stores, div, rem and system ops other than ebreak are illegal
`timescale 1ns/1ps

module rv64_idu (
  input  logic [31:0]                     i_inst,
  output logic [rv64_pkg::XLEN-1:0]       o_imm,
  output logic [rv64_pkg::REG_ADDR_W-1:0] o_rs1,
  output logic [rv64_pkg::REG_ADDR_W-1:0] o_rs2,
  output logic [rv64_pkg::REG_ADDR_W-1:0] o_rd,
  output logic [rv64_pkg::ALU_OP_W-1:0]   o_alu_op,
  output logic                            o_asrc,
  output logic [1:0]                      o_bsrc,
  output logic [rv64_pkg::BR_W-1:0]       o_branch,
  output logic                            o_word_cut,
  output logic                            o_reg_wr,
  output logic                            o_ebreak,
  output logic                            o_illegal
);

  wire [6:0] opcode = i_inst[6:0];
  wire [2:0] funct3 = i_inst[14:12];
  wire [6:0] funct7 = i_inst[31:25];

  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = i_inst[11:7];

  wire [63:0] imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  wire [63:0] imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  wire [63:0] imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  wire [63:0] imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  wire [63:0] imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  wire op_lui   = (opcode == 7'b0110111);
  wire op_auipc = (opcode == 7'b0010111);
  wire op_jal   = (opcode == 7'b1101111);
  wire op_jalr  = (opcode == 7'b1100111) & (funct3 == 3'b000);
  wire op_br    = (opcode == 7'b1100011);
  wire op_store = (opcode == 7'b0100011);  // only for the immediate, never legal
  wire op_imm   = (opcode == 7'b0010011);
  wire op_immw  = (opcode == 7'b0011011);
  wire op_reg   = (opcode == 7'b0110011);
  wire op_regw  = (opcode == 7'b0111011);

  wire f7_zero = (funct7 == 7'b0000000);
  wire f7_alt  = (funct7 == 7'b0100000);
  wire f7_mul  = (funct7 == 7'b0000001);

  wire v_br   = op_br & (funct3[2:1] != 2'b01);
  // 64-bit immediate shifts carry a 6-bit shamt, so funct7 bit 0 is free
  wire v_imm  = op_imm & ((funct3 == 3'b001) ? (funct7[6:1] == 6'b000000) :
                (funct3 == 3'b101) ? (funct7[6:1] == 6'b000000 || funct7[6:1] == 6'b010000) :
                1'b1);
  wire v_immw = op_immw & ((funct3 == 3'b000) | (funct3 == 3'b001) & f7_zero |
                (funct3 == 3'b101) & (f7_zero | f7_alt));
  wire v_reg  = op_reg & (f7_zero | f7_alt & (funct3 == 3'b000 || funct3 == 3'b101) |
                f7_mul & (funct3 == 3'b000));
  wire v_regw = op_regw & ((funct3 == 3'b000) & (f7_zero | f7_alt | f7_mul) |
                (funct3 == 3'b001) & f7_zero | (funct3 == 3'b101) & (f7_zero | f7_alt));

  wire is_mul  = (v_reg | v_regw) & f7_mul;
  wire is_sub  = (v_reg | v_regw) & f7_alt;  // sub and sra share funct7
  wire is_ebrk = (i_inst == 32'h0010_0073);
  wire legal   = |{op_lui, op_auipc, op_jal, op_jalr, v_br, v_imm, v_immw, v_reg, v_regw,
                   is_ebrk};

  assign o_ebreak   = is_ebrk;
  assign o_illegal  = !legal;
  assign o_reg_wr   = legal & !v_br & !is_ebrk;
  assign o_word_cut = v_immw | v_regw;
  assign o_asrc     = (op_auipc | op_jal | op_jalr) ? rv64_pkg::ASRC_PC : rv64_pkg::ASRC_RS1;
  assign o_bsrc     = (op_jal | op_jalr) ? rv64_pkg::BSRC_FOUR :
                      (op_lui | op_auipc | v_imm | v_immw) ? rv64_pkg::BSRC_IMM :
                      rv64_pkg::BSRC_RS2;

  always_comb begin
    if (op_lui | op_auipc)
      o_imm = imm_u;
    else if (op_jal)
      o_imm = imm_j;
    else if (op_br)
      o_imm = imm_b;
    else if (op_store)
      o_imm = imm_s;
    else
      o_imm = imm_i;
  end

  always_comb begin
    o_alu_op = rv64_pkg::ALU_NONE;
    if (is_mul)
      o_alu_op = rv64_pkg::ALU_MUL;
    else if (op_lui)
      o_alu_op = rv64_pkg::ALU_COPY_B;
    else if (op_auipc | op_jal | op_jalr)
      o_alu_op = rv64_pkg::ALU_ADD;
    else if (v_br)
      o_alu_op = funct3[1] ? rv64_pkg::ALU_SLTU : rv64_pkg::ALU_SLT;  // bltu/bgeu unsigned
    else if (v_imm | v_immw | v_reg | v_regw) begin
      case (funct3)
        3'b000:  o_alu_op = is_sub ? rv64_pkg::ALU_SUB : rv64_pkg::ALU_ADD;
        3'b001:  o_alu_op = rv64_pkg::ALU_SLL;
        3'b010:  o_alu_op = rv64_pkg::ALU_SLT;
        3'b011:  o_alu_op = rv64_pkg::ALU_SLTU;
        3'b100:  o_alu_op = rv64_pkg::ALU_XOR;
        3'b101:  o_alu_op = funct7[5] ? rv64_pkg::ALU_SRA : rv64_pkg::ALU_SRL;
        3'b110:  o_alu_op = rv64_pkg::ALU_OR;
        default: o_alu_op = rv64_pkg::ALU_AND;
      endcase
    end
  end

  always_comb begin
    o_branch = rv64_pkg::BR_NONE;
    if (op_jal)
      o_branch = rv64_pkg::BR_JAL;
    else if (op_jalr)
      o_branch = rv64_pkg::BR_JALR;
    else if (v_br) begin
      case (funct3)
        3'b000:  o_branch = rv64_pkg::BR_EQ;
        3'b001:  o_branch = rv64_pkg::BR_NE;
        3'b100:  o_branch = rv64_pkg::BR_LT;
        3'b101:  o_branch = rv64_pkg::BR_GE;
        3'b110:  o_branch = rv64_pkg::BR_LTU;
        default: o_branch = rv64_pkg::BR_GEU;
      endcase
    end
  end

endmodule

//--- source/rv64_pkg.sv
// shared constants for the RV64I execute pipe; BR_LTU and BR_GEU reuse the BR_LT and BR_GE codes
package rv64_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int ALU_OP_W   = 5;
  localparam int BR_W       = 3;

  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 5'b00000;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 5'b00001;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 5'b00010;
  localparam logic [ALU_OP_W-1:0] ALU_COPY_B = 5'b00011;  // lui
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 5'b00100;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 5'b00101;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 5'b00110;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 5'b00111;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 5'b01000;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 5'b01010;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 5'b01101;
  localparam logic [ALU_OP_W-1:0] ALU_MUL    = 5'b11100;
  localparam logic [ALU_OP_W-1:0] ALU_NONE   = 5'b11111;

  // unsigned branches share codes with signed ones, the alu op tells them apart
  localparam logic [BR_W-1:0] BR_NONE = 3'b000;
  localparam logic [BR_W-1:0] BR_JAL  = 3'b001;
  localparam logic [BR_W-1:0] BR_JALR = 3'b010;
  localparam logic [BR_W-1:0] BR_EQ   = 3'b100;
  localparam logic [BR_W-1:0] BR_NE   = 3'b101;
  localparam logic [BR_W-1:0] BR_LT   = 3'b110;
  localparam logic [BR_W-1:0] BR_GE   = 3'b111;
  localparam logic [BR_W-1:0] BR_LTU  = 3'b110;
  localparam logic [BR_W-1:0] BR_GEU  = 3'b111;

  localparam logic ASRC_RS1 = 1'b0;
  localparam logic ASRC_PC  = 1'b1;

  localparam logic [1:0] BSRC_RS2  = 2'b00;
  localparam logic [1:0] BSRC_IMM  = 2'b01;
  localparam logic [1:0] BSRC_FOUR = 2'b10;  // return address pc + 4

endpackage

//--- source/rv64_regfile.sv
// 32 x 64-bit, asynchronous reads with no internal write-through; x0 reads zero
`timescale 1ns/1ps

module rv64_regfile (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic [rv64_pkg::REG_ADDR_W-1:0] i_ra,
  input  logic [rv64_pkg::REG_ADDR_W-1:0] i_rb,
  output logic [rv64_pkg::XLEN-1:0]       o_rdata_a,
  output logic [rv64_pkg::XLEN-1:0]       o_rdata_b,
  input  logic                            i_we,
  input  logic [rv64_pkg::REG_ADDR_W-1:0] i_wa,
  input  logic [rv64_pkg::XLEN-1:0]       i_wdata
);

  logic [rv64_pkg::XLEN-1:0] regs [2**rv64_pkg::REG_ADDR_W];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 2**rv64_pkg::REG_ADDR_W; i++)
        regs[i] <= '0;
    end else if (i_we && i_wa != '0) begin  // x0 writes dropped
      regs[i_wa] <= i_wdata;
    end
  end

  assign o_rdata_a = (i_ra == '0) ? '0 : regs[i_ra];
  assign o_rdata_b = (i_rb == '0) ? '0 : regs[i_rb];

  // write port comes from the ex stage, whose rd may be zero
  assert property (@(posedge i_clk) disable iff (!i_rst_n) regs[0] == '0);

endmodule

//--- test/tb_clock_gen.sv
// 8 ns clock from time zero; reset low for 8 rising edges, released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;  // 8 ns period
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (8) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

//--- test/tb_rv64_core_pipe.sv
// random RV64I stream from register pool x0..x7; stops at the first error, no wave dump
`timescale 1ns/1ps

module tb_rv64_core_pipe;

  typedef struct packed {
    logic                            we;
    logic [rv64_pkg::REG_ADDR_W-1:0] rd;
    logic [rv64_pkg::XLEN-1:0]       data;
    logic                            redirect;
    logic [rv64_pkg::XLEN-1:0]       target;
    logic                            ebreak;
    logic                            illegal;
    logic [31:0]                     due;
  } expect_t;

  logic                            clk;
  logic                            rst_n;
  logic                            i_inst_valid;
  logic [31:0]                     i_inst;
  logic [rv64_pkg::XLEN-1:0]       i_pc;
  logic                            o_wb_valid;
  logic                            o_wb_we;
  logic [rv64_pkg::REG_ADDR_W-1:0] o_wb_rd;
  logic [rv64_pkg::XLEN-1:0]       o_wb_data;
  logic                            o_redirect;
  logic [rv64_pkg::XLEN-1:0]       o_redirect_pc;
  logic                            o_ebreak;
  logic                            o_illegal;

  logic [rv64_pkg::XLEN-1:0] gpr [32];  // reference register state
  logic [rv64_pkg::XLEN-1:0] pc = 64'h0000_0000_8000_0000;
  logic [31:0]               cycle = '0;
  expect_t                   expq [$];

  tb_clock_gen tb_clock_gen_i (.o_clk(clk), .o_rst_n(rst_n));

  rv64_core_pipe rv64_core_pipe_i (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_inst_valid  (i_inst_valid),
    .i_inst        (i_inst),
    .i_pc          (i_pc),
    .o_wb_valid    (o_wb_valid),
    .o_wb_we       (o_wb_we),
    .o_wb_rd       (o_wb_rd),
    .o_wb_data     (o_wb_data),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc),
    .o_ebreak      (o_ebreak),
    .o_illegal     (o_illegal)
  );

  always @(posedge clk) cycle <= cycle + 1;

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_data(input string name, input logic [rv64_pkg::XLEN-1:0] got,
                              input logic [rv64_pkg::XLEN-1:0] exp);
    if (got !== exp)
      fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic compare_reg(input string name, input logic [rv64_pkg::REG_ADDR_W-1:0] got,
                             input logic [rv64_pkg::REG_ADDR_W-1:0] exp);
    if (got !== exp)
      fail_now($sformatf("mismatch at %0t: %s got x%0d expected x%0d", $time, name, got, exp));
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic compare_pc(input string name, input logic [rv64_pkg::XLEN-1:0] got,
                            input logic [rv64_pkg::XLEN-1:0] exp);
    if (got !== exp)
      fail_now($sformatf("mismatch at %0t: %s got pc %h expected pc %h", $time, name, got, exp));
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // RV64I semantics plus mul/mulw, updates gpr in program order
  function automatic expect_t reference_result(input logic [31:0] inst,
      input logic [rv64_pkg::XLEN-1:0] ipc);
    expect_t     e;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [63:0] a, b, op2, res, tgt;
    logic [63:0] imm_i, imm_u, imm_b, imm_j;
    logic [31:0] r32;
    logic        ok, wr, take, ebrk;
    opc   = inst[6:0];
    f3    = inst[14:12];
    f7    = inst[31:25];
    rd    = inst[11:7];
    a     = gpr[inst[19:15]];
    b     = gpr[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    e = '0;
    ok = 1'b0;
    wr = 1'b1;
    take = 1'b0;
    ebrk = 1'b0;
    res = '0;
    tgt = '0;
    case (opc)
      7'h37: begin ok = 1'b1; res = imm_u; end
      7'h17: begin ok = 1'b1; res = ipc + imm_u; end
      7'h6f: begin ok = 1'b1; res = ipc + 4; take = 1'b1; tgt = ipc + imm_j; end
      7'h67: begin
        ok = (f3 == 3'd0);
        res = ipc + 4;
        take = 1'b1;
        tgt = (a + imm_i) & ~64'd1;
      end
      7'h63: begin
        wr = 1'b0;
        ok = (f3 != 3'd2) && (f3 != 3'd3);
        tgt = ipc + imm_b;
        case (f3)
          3'd0: take = (a == b);
          3'd1: take = (a != b);
          3'd4: take = ($signed(a) < $signed(b));
          3'd5: take = ($signed(a) >= $signed(b));
          3'd6: take = (a < b);
          default: take = (a >= b);
        endcase
      end
      7'h13, 7'h33: begin
        op2 = opc[5] ? b : imm_i;
        ok = 1'b1;
        case (f3)
          3'd0: res = (opc[5] && f7 == 7'h20) ? a - op2 : a + op2;
          3'd1: res = a << op2[5:0];
          3'd2: res = ($signed(a) < $signed(op2)) ? 64'd1 : 64'd0;
          3'd3: res = (a < op2) ? 64'd1 : 64'd0;
          3'd4: res = a ^ op2;
          3'd5: res = f7[5] ? $unsigned($signed(a) >>> op2[5:0]) : a >> op2[5:0];
          3'd6: res = a | op2;
          default: res = a & op2;
        endcase
        if (opc[5] && f7 == 7'h01) begin
          ok = (f3 == 3'd0);
          res = a * b;
        end else if (opc[5])
          ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (f3 == 3'd1 || f3 == 3'd5)
          ok = (inst[31:26] == 6'h00) || (f3 == 3'd5 && inst[31:26] == 6'h10);
      end
      7'h1b, 7'h3b: begin
        op2 = opc[5] ? b : imm_i;
        case (f3)
          3'd0: r32 = (opc[5] && f7 == 7'h20) ? a[31:0] - op2[31:0] :
                      (opc[5] && f7 == 7'h01) ? a[31:0] * op2[31:0] : a[31:0] + op2[31:0];
          3'd1: r32 = a[31:0] << op2[4:0];
          3'd5: r32 = f7[5] ? $unsigned($signed(a[31:0]) >>> op2[4:0]) : a[31:0] >> op2[4:0];
          default: r32 = '0;
        endcase
        res = {{32{r32[31]}}, r32};
        if (f3 == 3'd0)
          ok = !opc[5] || f7 == 7'h00 || f7 == 7'h20 || f7 == 7'h01;
        else if (f3 == 3'd1)
          ok = (f7 == 7'h00);
        else if (f3 == 3'd5)
          ok = (f7 == 7'h00) || (f7 == 7'h20);
      end
      7'h73: begin ok = (inst == 32'h0010_0073); ebrk = ok; wr = 1'b0; end
      default: ok = 1'b0;  // loads, stores, fence and the rest
    endcase
    e.we       = ok && wr;
    e.rd       = rd;
    e.data     = res;
    e.redirect = ok && take;
    e.target   = tgt;
    e.ebreak   = ebrk;
    e.illegal  = !ok;
    if (e.we && rd != 5'd0)
      gpr[rd] = res;
    return e;
  endfunction

  function automatic logic [31:0] random_inst();
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3, wf3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [31:0] w;
    rd  = 5'($urandom_range(0, 7));
    rs1 = 5'($urandom_range(0, 7));
    rs2 = 5'($urandom_range(0, 7));
    f3  = 3'($urandom);
    imm = 12'($urandom);
    f7  = ($urandom_range(0, 2) == 0) ? 7'h00 : ($urandom_range(0, 1) ? 7'h20 : 7'h01);
    wf3 = ($urandom_range(0, 2) == 0) ? 3'd0 : ($urandom_range(0, 1) ? 3'd1 : 3'd5);
    case ($urandom_range(0, 9))
      0: w = enc_r(f7, rs2, rs1, f3, rd, 7'h33);
      1: w = enc_i((f3 == 3'd1 || f3 == 3'd5) ? {f7[6:1], imm[5:0]} : imm, rs1, f3, rd, 7'h13);
      2: w = enc_r(f7, rs2, rs1, wf3, rd, 7'h3b);
      3: w = enc_i((wf3 == 3'd0) ? imm : {f7, imm[4:0]}, rs1, wf3, rd, 7'h1b);
      4: w = enc_u(20'($urandom), rd, $urandom_range(0, 1) ? 7'h37 : 7'h17);
      5: w = enc_b(13'($urandom), rs2, rs1, f3);
      6: w = enc_j(21'($urandom), rd);
      7: w = enc_i(imm, rs1, 3'd0, rd, 7'h67);
      8: case ($urandom_range(0, 3))
           0: w = 32'h0010_0073;  // ebreak
           1: w = enc_i(imm, rs1, f3, rd, 7'h03);  // load
           2: w = enc_i(imm, rs1, f3, rd, 7'h23);  // store
           default: w = enc_r(7'h01, rs2, rs1, {1'b1, f3[1:0]}, rd, f3[2] ? 7'h33 : 7'h3b);
         endcase
      default: w = $urandom;
    endcase
    return w;
  endfunction

  task automatic send(input logic [31:0] inst);
    expect_t e;
    @(negedge clk);
    e = reference_result(inst, pc);
    e.due = cycle + 2;  // sampled at the next edge, visible one edge later
    expq.push_back(e);
    i_inst_valid = 1'b1;
    i_inst = inst;
    i_pc = pc;
    pc = pc + 4;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      i_inst_valid = 1'b0;
      i_inst = $urandom;
    end
  endtask

  always @(negedge clk) begin
    expect_t e;
    if (rst_n) begin
      if (expq.size() != 0 && expq[0].due < cycle)
        fail_now($sformatf("no output pulse for the instruction due in cycle %0d", expq[0].due));
      else if (o_wb_valid && expq.size() == 0)
        fail_now("output pulse without an accepted instruction");
      else if (o_wb_valid) begin
        e = expq.pop_front();
        if (e.due != cycle)
          fail_now($sformatf("output came in cycle %0d, one cycle after sampling is %0d",
                             cycle, e.due));
        compare_bit("wb_we", o_wb_we, e.we);
        compare_bit("redirect", o_redirect, e.redirect);
        compare_bit("ebreak", o_ebreak, e.ebreak);
        compare_bit("illegal", o_illegal, e.illegal);
        if (e.we) begin
          compare_reg("wb_rd", o_wb_rd, e.rd);
          compare_data("wb_data", o_wb_data, e.data);
        end
        if (e.redirect)
          compare_pc("redirect_pc", o_redirect_pc, e.target);
      end
    end
  end

  initial begin
    int          waited;
    logic [31:0] seed_ret;
    seed_ret = $urandom(32'ha956_5457);
    i_inst_valid = 1'b0;
    i_inst = '0;
    i_pc = '0;
    foreach (gpr[i]) gpr[i] = '0;
    waited = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 40)
        fail_now("reset was never released");
    end
    compare_bit("wb_valid after reset", o_wb_valid, 1'b0);
    compare_bit("wb_we after reset", o_wb_we, 1'b0);
    compare_bit("redirect after reset", o_redirect, 1'b0);
    compare_bit("ebreak after reset", o_ebreak, 1'b0);
    compare_bit("illegal after reset", o_illegal, 1'b0);
    send(enc_i(12'hff9, 5'd0, 3'd0, 5'd1, 7'h13));       // addi x1, x0, -7
    send(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2, 7'h33));   // add x2, x1, x1 via bypass
    send(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3, 7'h33));   // sub x3, x2, x1
    send(enc_i(12'h005, 5'd3, 3'd0, 5'd0, 7'h13));       // addi x0, x3, 5
    send(enc_r(7'h00, 5'd3, 5'd0, 3'd0, 5'd4, 7'h33));   // add x4, x0, x3
    send(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd5, 7'h3b));   // mulw x5, x1, x2
    for (int n = 0; n < 600; n++) begin
      send(random_inst());
      if ($urandom_range(0, 3) == 0)
        idle($urandom_range(1, 2));
    end
    idle(1);
    waited = 0;
    while (expq.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > 10)
        fail_now("outputs still pending after the input stream ended");
    end
    idle(3);  // catch stray pulses
    $display("Test completed successfully");
    $finish;
  end

endmodule
